//--- compile.f
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_branch.sv
verilog/exu_result_mux.sv
verilog/exu_pipe_reg.sv
verilog/exu_top.sv
verif/exu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.
# The exit status is the simulator's own: non-zero on any failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f compile.f \
    --top-module exu_tb \
    -Mdir obj_dir \
    && ./obj_dir/Vexu_tb \
    || exit 1

//--- verif/exu_tb.sv
/*
 * Self-checking testbench for the execute stage. Random instructions and
 * a random downstream stall and flush pattern drive exu_top; a reference
 * model predicts every stage 3 record and every forwarding value.
 */
`default_nettype none

module exu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int XLEN        = 32;
    localparam int SHW         = $clog2(XLEN);      // Shift amount width
    localparam int CLK_PERIOD  = 20;
    localparam int N_INSTR     = 600;
    localparam int WATCHDOG_NS = N_INSTR * CLK_PERIOD * 4;

    localparam exu_pkg::uop_t ALU_OPS [10] = '{exu_pkg::UOP_ADD, exu_pkg::UOP_SUB,
        exu_pkg::UOP_XOR, exu_pkg::UOP_OR, exu_pkg::UOP_AND, exu_pkg::UOP_SLL,
        exu_pkg::UOP_SRL, exu_pkg::UOP_SRA, exu_pkg::UOP_SLT, exu_pkg::UOP_SLTU};
    localparam exu_pkg::uop_t CFU_OPS [8] = '{exu_pkg::UOP_BEQ, exu_pkg::UOP_BNE,
        exu_pkg::UOP_BLT, exu_pkg::UOP_BGE, exu_pkg::UOP_BLTU, exu_pkg::UOP_BGEU,
        exu_pkg::UOP_JALI, exu_pkg::UOP_JALR};

    typedef struct packed {
        exu_pkg::reg_addr_t rd;
        logic [XLEN-1:0]    opr_a;
        logic [XLEN-1:0]    opr_b;
        exu_pkg::uop_t      uop;
        exu_pkg::fu_t       fu;
        logic               trap;
        exu_pkg::size_t     size;
        exu_pkg::instr_t    instr;
        logic [XLEN-1:0]    fwd_wdata;  // Forwarding, checked at stage 2
        logic               fwd_load;
        logic               fwd_csr;
    } stage_rec_t;

    logic g_clk = 1'b0;
    logic i_arst_n, i_flush, i_s2_valid, i_s2_trap, i_s3_busy;
    exu_pkg::reg_addr_t i_s2_rd;
    logic [XLEN-1:0] i_s2_opr_a, i_s2_opr_b, i_s2_opr_c;
    exu_pkg::uop_t i_s2_uop;
    exu_pkg::fu_t i_s2_fu;
    exu_pkg::size_t i_s2_size;
    exu_pkg::instr_t i_s2_instr;
    logic o_s2_busy, o_s3_valid, o_s3_trap, o_fwd_load, o_fwd_csr;
    exu_pkg::reg_addr_t o_s3_rd, o_fwd_rd;
    logic [XLEN-1:0] o_s3_opr_a, o_s3_opr_b, o_fwd_wdata;
    exu_pkg::uop_t o_s3_uop;
    exu_pkg::fu_t o_s3_fu;
    exu_pkg::size_t o_s3_size;
    exu_pkg::instr_t o_s3_instr;

    stage_rec_t exp_q [$];                          // Accepted, not yet retired
    logic s2_done = 1'b0;                           // Stage 2 entry left at last edge
    int accepted = 0;
    int retired = 0;
    int dropped = 0;

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    exu_top #(.XLEN(XLEN)) u_dut (.*);              // Port names match the TB signals

    // Reference model
    // ------------------------------
    function automatic stage_rec_t model_stage(input exu_pkg::fu_t fu, input exu_pkg::uop_t uop,
        input exu_pkg::reg_addr_t rd, input logic trap, input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b, input logic [XLEN-1:0] c, input exu_pkg::size_t size,
        input exu_pkg::instr_t instr);
        stage_rec_t r;
        logic [XLEN-1:0] alu;
        logic [XLEN-1:0] sum;
        logic signed [XLEN-1:0] sa;
        logic taken;
        logic is_cond;
        sa  = a;
        sum = a + b;
        case (uop)
            exu_pkg::UOP_ADD:  alu = sum;
            exu_pkg::UOP_SUB:  alu = a - b;
            exu_pkg::UOP_XOR:  alu = a ^ b;
            exu_pkg::UOP_OR:   alu = a | b;
            exu_pkg::UOP_AND:  alu = a & b;
            exu_pkg::UOP_SLL:  alu = a << b[SHW-1:0];
            exu_pkg::UOP_SRL:  alu = a >> b[SHW-1:0];
            exu_pkg::UOP_SRA:  alu = sa >>> b[SHW-1:0];       // Sign fill
            exu_pkg::UOP_SLT:  alu = {{(XLEN-1){1'b0}}, sa < $signed(b)};
            exu_pkg::UOP_SLTU: alu = {{(XLEN-1){1'b0}}, a < b};
            default:           alu = '0;
        endcase
        is_cond = 1'b1;
        case (uop)
            exu_pkg::UOP_BEQ:  taken = (a == b);
            exu_pkg::UOP_BNE:  taken = (a != b);
            exu_pkg::UOP_BLT:  taken = (sa < $signed(b));
            exu_pkg::UOP_BGE:  taken = (sa >= $signed(b));
            exu_pkg::UOP_BLTU: taken = (a < b);
            exu_pkg::UOP_BGEU: taken = (a >= b);
            default: begin
                taken   = 1'b0;
                is_cond = 1'b0;                             // Jumps keep their code
            end
        endcase
        r = '0;
        r.rd    = rd;
        r.uop   = uop;
        r.fu    = fu;
        r.trap  = trap;
        r.size  = size;
        r.instr = instr;
        if (fu[exu_pkg::FU_ALU]) begin
            r.opr_a = alu;
        end else if (fu[exu_pkg::FU_LSU]) begin
            r.opr_a = sum;                                  // Address
            r.opr_b = c;                                    // Store data
        end else if (fu[exu_pkg::FU_CFU]) begin
            if (is_cond) r.uop = taken ? exu_pkg::UOP_TAKEN : exu_pkg::UOP_NOT_TAKEN;
            r.opr_a = (uop == exu_pkg::UOP_JALR) ? {sum[XLEN-1:1], 1'b0} : {c[XLEN-1:1], 1'b0};
        end else if (fu[exu_pkg::FU_CSR]) begin
            r.opr_a = a;
            r.opr_b = c;
        end
        if (trap) r.opr_b = {{(XLEN-$bits(rd)){1'b0}}, rd};  // Cause overrides unit value
        r.fwd_wdata = fu[exu_pkg::FU_ALU] ? alu : '0;
        r.fwd_load  = fu[exu_pkg::FU_LSU] && uop[exu_pkg::LSU_LOAD_BIT];
        r.fwd_csr   = fu[exu_pkg::FU_CSR];
        return r;
    endfunction

    // Checks
    // ------------------------------
    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_stage(input stage_rec_t e, input exu_pkg::reg_addr_t rd,
        input logic [XLEN-1:0] opr_a, input logic [XLEN-1:0] opr_b, input exu_pkg::uop_t uop,
        input exu_pkg::fu_t fu, input logic trap, input exu_pkg::size_t size,
        input exu_pkg::instr_t instr);
        if (rd !== e.rd || opr_a !== e.opr_a || opr_b !== e.opr_b || uop !== e.uop ||
            fu !== e.fu || trap !== e.trap || size !== e.size || instr !== e.instr) begin
            $display("Mismatch at %0t: stage 3 rd=%0d a=%h b=%h uop=%b fu=%b trap=%b sz=%0d i=%h",
                     $time, rd, opr_a, opr_b, uop, fu, trap, size, instr);
            $display("  expected       rd=%0d a=%h b=%h uop=%b fu=%b trap=%b sz=%0d i=%h",
                     e.rd, e.opr_a, e.opr_b, e.uop, e.fu, e.trap, e.size, e.instr);
            abort_run();
        end
    endtask

    task automatic compare_fwd(input stage_rec_t e, input exu_pkg::reg_addr_t rd,
        input logic [XLEN-1:0] wdata, input logic load, input logic csr);
        if (rd !== e.rd || wdata !== e.fwd_wdata ||
            load !== e.fwd_load || csr !== e.fwd_csr) begin
            $display("Mismatch at %0t: forwarding rd=%0d wdata=%h load=%b csr=%b",
                     $time, rd, wdata, load, csr);
            $display("  expected %0d %h %b %b", e.rd, e.fwd_wdata, e.fwd_load, e.fwd_csr);
            abort_run();
        end
    endtask

    task automatic compare_ctrl(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Stimulus
    // ------------------------------
    function automatic logic [XLEN-1:0] rand_word();
        return XLEN'({$urandom(), $urandom()});
    endfunction

    task automatic drive_random_instr();
        logic [1:0] unit;
        logic       is_load;
        unit       = 2'($urandom());
        is_load    = 1'($urandom());
        i_s2_valid = 1'b1;
        i_s2_fu    = '0;
        case (unit)
            2'd0: begin
                i_s2_fu[exu_pkg::FU_ALU] = 1'b1;
                i_s2_uop = ALU_OPS[4'($urandom_range(9))];
            end
            2'd1: begin
                i_s2_fu[exu_pkg::FU_LSU] = 1'b1;
                i_s2_uop = 5'($urandom_range(7));             // Access width bits
                i_s2_uop[exu_pkg::LSU_LOAD_BIT]  = is_load;
                i_s2_uop[exu_pkg::LSU_STORE_BIT] = !is_load;
            end
            2'd2: begin
                i_s2_fu[exu_pkg::FU_CFU] = 1'b1;
                i_s2_uop = CFU_OPS[3'($urandom())];
            end
            default: begin
                i_s2_fu[exu_pkg::FU_CSR] = 1'b1;
                i_s2_uop = 5'($urandom());
            end
        endcase
        i_s2_opr_a = rand_word();
        i_s2_opr_b = ($urandom_range(3) == 0) ? i_s2_opr_a : rand_word(); // Hit equal compares
        i_s2_opr_c = rand_word();
        i_s2_trap  = ($urandom_range(7) == 0);
        i_s2_rd    = 5'($urandom());
        i_s2_size  = 2'($urandom());
        i_s2_instr = $urandom();
    endtask

    // Scoreboard, samples at the rising edge
    always @(posedge g_clk) begin
        stage_rec_t now_rec;
        stage_rec_t head;
        logic       busy_exp;
        if (i_arst_n) begin
            busy_exp = (exp_q.size() != 0) && i_s3_busy;
            compare_ctrl("o_s3_valid", o_s3_valid, exp_q.size() != 0);
            compare_ctrl("o_s2_busy", o_s2_busy, busy_exp);
            now_rec = model_stage(i_s2_fu, i_s2_uop, i_s2_rd, i_s2_trap, i_s2_opr_a,
                                  i_s2_opr_b, i_s2_opr_c, i_s2_size, i_s2_instr);
            compare_fwd(now_rec, o_fwd_rd, o_fwd_wdata, o_fwd_load, o_fwd_csr);
            if (exp_q.size() != 0) begin
                head = exp_q[0];                            // Also checked while stalled
                compare_stage(head, o_s3_rd, o_s3_opr_a, o_s3_opr_b, o_s3_uop, o_s3_fu,
                              o_s3_trap, o_s3_size, o_s3_instr);
                if (i_flush || !i_s3_busy) begin
                    head = exp_q.pop_front();
                    if (i_flush) dropped++;                 // Held entry squashed
                    else retired++;
                end
            end
            s2_done = i_s2_valid && (i_flush || !busy_exp);
            if (i_s2_valid && !i_flush && !busy_exp) begin
                exp_q.push_back(now_rec);
                accepted++;
            end
        end
    end

    initial begin
        int issued;
        void'($urandom(84));
        issued     = 0;
        i_arst_n   = 1'b0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b1;                                  // Busy must not leak out of reset
        i_s2_valid = 1'b0;
        i_s2_trap  = 1'b0;
        i_s2_rd    = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_s2_uop   = '0;
        i_s2_fu    = '0;
        i_s2_size  = '0;
        i_s2_instr = '0;
        repeat (10) @(posedge g_clk);
        @(negedge g_clk);
        i_arst_n = 1'b1;
        compare_ctrl("o_s3_valid after reset", o_s3_valid, 1'b0);
        compare_ctrl("o_s2_busy after reset", o_s2_busy, 1'b0);
        i_s3_busy = 1'b0;
        while (issued < N_INSTR) begin
            @(negedge g_clk);
            if (i_s2_valid && s2_done) issued++;
            if (issued < N_INSTR) begin
                i_s3_busy = ($urandom_range(3) == 0);
                i_flush   = ($urandom_range(49) == 0);
                if (!i_s2_valid || s2_done) begin
                    if ($urandom_range(7) != 0) drive_random_instr();
                    else i_s2_valid = 1'b0;                 // Idle bubble
                end
            end
        end
        i_s2_valid = 1'b0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b0;
        while (exp_q.size() != 0) @(negedge g_clk);
        @(negedge g_clk);
        if (retired > 0 && dropped > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Stimulus too weak: %0d accepted, %0d retired, %0d flushed while held",
                     accepted, retired, dropped);
            abort_run();
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish in %0d ns", WATCHDOG_NS);
        abort_run();
    end

endmodule

`default_nettype wire

//--- verilog/exu_top.sv
/*
 * Execute stage of the pipeline. ALU, branch resolution and result
 * selection are combinational, the pipe register adds one cycle.
 * Set XLEN here, it is passed down to every unit.
 */
`default_nettype none

module exu_top #(
    parameter int unsigned XLEN = 32
) (
    input  wire                      g_clk,
    input  wire                      i_arst_n,
    input  wire                      i_flush,      // Squash this stage

    // Stage 2 side
    input  wire                      i_s2_valid,
    input  wire exu_pkg::reg_addr_t  i_s2_rd,
    input  wire [XLEN-1:0]           i_s2_opr_a,
    input  wire [XLEN-1:0]           i_s2_opr_b,
    input  wire [XLEN-1:0]           i_s2_opr_c,
    input  wire exu_pkg::uop_t       i_s2_uop,
    input  wire exu_pkg::fu_t        i_s2_fu,
    input  wire                      i_s2_trap,
    input  wire exu_pkg::size_t      i_s2_size,
    input  wire exu_pkg::instr_t     i_s2_instr,
    output logic                     o_s2_busy,

    // Stage 3 side
    output logic                     o_s3_valid,
    output exu_pkg::reg_addr_t       o_s3_rd,
    output logic [XLEN-1:0]          o_s3_opr_a,
    output logic [XLEN-1:0]          o_s3_opr_b,
    output exu_pkg::uop_t            o_s3_uop,
    output exu_pkg::fu_t             o_s3_fu,
    output logic                     o_s3_trap,
    output exu_pkg::size_t           o_s3_size,
    output exu_pkg::instr_t          o_s3_instr,
    input  wire                      i_s3_busy,

    // Forwarding, combinational from stage 2
    output exu_pkg::reg_addr_t       o_fwd_rd,
    output logic [XLEN-1:0]          o_fwd_wdata,
    output logic                     o_fwd_load,
    output logic                     o_fwd_csr
);

    logic [XLEN-1:0]  alu_result;
    logic [XLEN-1:0]  add_result;   // Shared by LSU and JALR
    logic             cmp_eq;
    logic             cmp_lt_s;
    logic             cmp_lt_u;
    exu_pkg::uop_t    cfu_uop;
    logic [XLEN-1:0]  cfu_target;
    logic [XLEN-1:0]  n_s3_opr_a;   // Into the pipe register
    logic [XLEN-1:0]  n_s3_opr_b;
    exu_pkg::uop_t    n_s3_uop;

    assign o_fwd_rd = i_s2_rd;

    // Units
    // ------------------------------
    exu_alu #(.XLEN(XLEN)) u_alu (
        .i_uop         (i_s2_uop),
        .i_lhs         (i_s2_opr_a),
        .i_rhs         (i_s2_opr_b),
        .o_result      (alu_result),
        .o_add_result  (add_result),
        .o_eq          (cmp_eq),
        .o_lt_signed   (cmp_lt_s),
        .o_lt_unsigned (cmp_lt_u)
    );

    exu_branch #(.XLEN(XLEN)) u_branch (
        .i_uop         (i_s2_uop),
        .i_opr_c       (i_s2_opr_c),
        .i_add_result  (add_result),
        .i_eq          (cmp_eq),
        .i_lt_signed   (cmp_lt_s),
        .i_lt_unsigned (cmp_lt_u),
        .o_uop         (cfu_uop),
        .o_target      (cfu_target)
    );

    exu_result_mux #(.XLEN(XLEN)) u_result_mux (
        .i_fu          (i_s2_fu),
        .i_uop         (i_s2_uop),
        .i_rd          (i_s2_rd),
        .i_trap        (i_s2_trap),
        .i_opr_a       (i_s2_opr_a),
        .i_opr_c       (i_s2_opr_c),
        .i_alu_result  (alu_result),
        .i_add_result  (add_result),
        .i_cfu_target  (cfu_target),
        .i_cfu_uop     (cfu_uop),
        .o_opr_a       (n_s3_opr_a),
        .o_opr_b       (n_s3_opr_b),
        .o_uop         (n_s3_uop),
        .o_fwd_wdata   (o_fwd_wdata),
        .o_fwd_load    (o_fwd_load),
        .o_fwd_csr     (o_fwd_csr)
    );

    // Pipeline register
    // ------------------------------
    exu_pipe_reg #(.XLEN(XLEN)) u_pipe_reg (
        .g_clk         (g_clk),
        .i_arst_n      (i_arst_n),
        .i_flush       (i_flush),
        .i_valid       (i_s2_valid),
        .i_busy        (i_s3_busy),
        .i_rd          (i_s2_rd),
        .i_opr_a       (n_s3_opr_a),
        .i_opr_b       (n_s3_opr_b),
        .i_uop         (n_s3_uop),
        .i_fu          (i_s2_fu),
        .i_trap        (i_s2_trap),
        .i_size        (i_s2_size),
        .i_instr       (i_s2_instr),
        .o_busy        (o_s2_busy),
        .o_valid       (o_s3_valid),
        .o_rd          (o_s3_rd),
        .o_opr_a       (o_s3_opr_a),
        .o_opr_b       (o_s3_opr_b),
        .o_uop         (o_s3_uop),
        .o_fu          (o_s3_fu),
        .o_trap        (o_s3_trap),
        .o_size        (o_s3_size),
        .o_instr       (o_s3_instr)
    );

endmodule

`default_nettype wire

//--- verilog/exu_pipe_reg.sv
/*
 * One-entry execute-to-writeback register. Takes a new entry on
 * valid and not busy, holds it while the next stage is busy, and
 * accepts the following entry in the cycle the held one leaves.
 */
`default_nettype none

module exu_pipe_reg #(
    parameter int unsigned XLEN = 32
) (
    input  wire                      g_clk,
    input  wire                      i_arst_n,
    input  wire                      i_flush,   // Drop entry, block transfer
    input  wire                      i_valid,   // Upstream has an entry
    input  wire                      i_busy,    // Downstream stalled
    input  wire exu_pkg::reg_addr_t  i_rd,
    input  wire [XLEN-1:0]           i_opr_a,
    input  wire [XLEN-1:0]           i_opr_b,
    input  wire exu_pkg::uop_t       i_uop,
    input  wire exu_pkg::fu_t        i_fu,
    input  wire                      i_trap,
    input  wire exu_pkg::size_t      i_size,
    input  wire exu_pkg::instr_t     i_instr,
    output logic                     o_busy,    // Back to upstream
    output logic                     o_valid,
    output exu_pkg::reg_addr_t       o_rd,
    output logic [XLEN-1:0]          o_opr_a,
    output logic [XLEN-1:0]          o_opr_b,
    output exu_pkg::uop_t            o_uop,
    output exu_pkg::fu_t             o_fu,
    output logic                     o_trap,
    output exu_pkg::size_t           o_size,
    output exu_pkg::instr_t          o_instr
);

    logic transfer; // Upstream entry is taken this edge

    assign o_busy   = o_valid && i_busy;
    assign transfer = i_valid && !o_busy && !i_flush;

    // Valid tracking
    // ------------------------------
    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;                // Held and incoming both dropped
        end else if (!o_busy) begin
            o_valid <= i_valid;             // Refill or drain
        end
    end

    // Payload
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (transfer) begin
            o_rd    <= i_rd;
            o_opr_a <= i_opr_a;
            o_opr_b <= i_opr_b;
            o_uop   <= i_uop;
            o_fu    <= i_fu;
            o_trap  <= i_trap;
            o_size  <= i_size;
            o_instr <= i_instr;
        end
    end

    // Downstream may sample at any stalled cycle, so nothing may move
    a_hold_stable: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        o_valid && i_busy |=>
            $stable({o_rd, o_opr_a, o_opr_b, o_uop, o_fu, o_trap, o_size, o_instr}))
        else $error("exu_pipe_reg: payload changed while stalled");

    a_flush_empty: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        i_flush |=> !o_valid)
        else $error("exu_pipe_reg: entry survived a flush");

endmodule

`default_nettype wire

//--- verilog/exu_result_mux.sv
/*
 * Selects the next-stage operands and micro-op from whichever unit the
 * one-hot select names, applies the trap cause override and drives the
 * forwarding signals back to decode.
 */
`default_nettype none

module exu_result_mux #(
    parameter int unsigned XLEN = 32
) (
    input  wire exu_pkg::fu_t        i_fu,          // One-hot unit select
    input  wire exu_pkg::uop_t       i_uop,         // Original micro-op
    input  wire exu_pkg::reg_addr_t  i_rd,          // Also the trap cause
    input  wire                      i_trap,        // Raise a trap
    input  wire [XLEN-1:0]           i_opr_a,
    input  wire [XLEN-1:0]           i_opr_c,
    input  wire [XLEN-1:0]           i_alu_result,
    input  wire [XLEN-1:0]           i_add_result,  // Load/store address
    input  wire [XLEN-1:0]           i_cfu_target,
    input  wire exu_pkg::uop_t       i_cfu_uop,     // Resolved branch code
    output logic [XLEN-1:0]          o_opr_a,
    output logic [XLEN-1:0]          o_opr_b,
    output exu_pkg::uop_t            o_uop,
    output logic [XLEN-1:0]          o_fwd_wdata,   // ALU result or zero
    output logic                     o_fwd_load,
    output logic                     o_fwd_csr
);

    logic                            fu_alu;
    logic                            fu_lsu;
    logic                            fu_cfu;
    logic                            fu_csr;
    logic [exu_pkg::TRAP_CAUSE_W-1:0] trap_cause;
    logic [XLEN-1:0]                 unit_opr_b;

    assign fu_alu = i_fu[exu_pkg::FU_ALU];
    assign fu_lsu = i_fu[exu_pkg::FU_LSU];
    assign fu_cfu = i_fu[exu_pkg::FU_CFU];
    assign fu_csr = i_fu[exu_pkg::FU_CSR];

    // Operand select
    // ------------------------------
    assign o_opr_a = {XLEN{fu_alu}} & i_alu_result |
                     {XLEN{fu_lsu}} & i_add_result |
                     {XLEN{fu_cfu}} & i_cfu_target |
                     {XLEN{fu_csr}} & i_opr_a      ;

    // ALU and CFU leave operand B at zero
    assign unit_opr_b = {XLEN{fu_lsu | fu_csr}} & i_opr_c; // Store data or CSR write value

    assign trap_cause = {{(exu_pkg::TRAP_CAUSE_W-$bits(i_rd)){1'b0}}, i_rd};
    assign o_opr_b    = i_trap ? {{(XLEN-exu_pkg::TRAP_CAUSE_W){1'b0}}, trap_cause}
                               : unit_opr_b;

    assign o_uop = fu_cfu ? i_cfu_uop : i_uop;

    // Forwarding
    // ------------------------------
    assign o_fwd_wdata = {XLEN{fu_alu}} & i_alu_result;
    assign o_fwd_load  = fu_lsu && i_uop[exu_pkg::LSU_LOAD_BIT];
    assign o_fwd_csr   = fu_csr;

    // Decode must hand over at most one unit, and an LSU op that is
    // exactly one of load or store
    always_comb begin
        assert ($onehot0(i_fu))
            else $error("exu_result_mux: unit select %b not one-hot", i_fu);
        assert (!fu_lsu || (i_uop[exu_pkg::LSU_LOAD_BIT] ^ i_uop[exu_pkg::LSU_STORE_BIT]))
            else $error("exu_result_mux: LSU op %b is not load xor store", i_uop);
    end

endmodule

`default_nettype wire

//--- verilog/exu_branch.sv
/*
 * Control flow unit. Resolves conditional branches from the ALU compare
 * flags and forms the bit-0-cleared jump or branch target.
 */
`default_nettype none

module exu_branch #(
    parameter int unsigned XLEN = 32
) (
    input  wire exu_pkg::uop_t   i_uop,          // Incoming CFU micro-op
    input  wire [XLEN-1:0]       i_opr_c,        // Precomputed target
    input  wire [XLEN-1:0]       i_add_result,   // A+B from the ALU
    input  wire                  i_eq,           // Compare flags from the ALU
    input  wire                  i_lt_signed,
    input  wire                  i_lt_unsigned,
    output exu_pkg::uop_t        o_uop,          // Resolved micro-op
    output logic [XLEN-1:0]      o_target        // Aligned target address
);

    logic                is_cond;    // Conditional branch code
    logic                taken;      // Branch condition holds
    logic [XLEN-1:0]     raw_target;

    // Condition select
    // ------------------------------
    always_comb begin
        is_cond = 1'b1;
        taken   = 1'b0;
        case (i_uop)
            exu_pkg::UOP_BEQ:  taken = i_eq;
            exu_pkg::UOP_BNE:  taken = !i_eq;
            exu_pkg::UOP_BLT:  taken = i_lt_signed;
            exu_pkg::UOP_BGE:  taken = !i_lt_signed;
            exu_pkg::UOP_BLTU: taken = i_lt_unsigned;
            exu_pkg::UOP_BGEU: taken = !i_lt_unsigned;
            default:           is_cond = 1'b0; // Jumps keep their code
        endcase
    end

    assign o_uop = !is_cond ? i_uop                  :
                   taken    ? exu_pkg::UOP_TAKEN     :
                              exu_pkg::UOP_NOT_TAKEN ;

    // Target formation
    // ------------------------------
    // Only JALR is register relative, everything else was formed upstream
    assign raw_target = (i_uop == exu_pkg::UOP_JALR) ? i_add_result : i_opr_c;
    assign o_target   = {raw_target[XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

//--- verilog/exu_alu.sv
/*
 * Single-cycle integer ALU. Also exports the raw adder sum for address
 * and jump target use, and the compare flags that resolve branches.
 */
`default_nettype none

module exu_alu #(
    parameter int unsigned XLEN = 32
) (
    input  wire exu_pkg::uop_t   i_uop,         // ALU micro-op
    input  wire [XLEN-1:0]       i_lhs,         // Operand A
    input  wire [XLEN-1:0]       i_rhs,         // Operand B
    output logic [XLEN-1:0]      o_result,      // Selected ALU result
    output logic [XLEN-1:0]      o_add_result,  // Always A+B
    output logic                 o_eq,          // A == B
    output logic                 o_lt_signed,   // A < B, signed
    output logic                 o_lt_unsigned  // A < B, unsigned
);

    localparam int unsigned SHAMT_W = $clog2(XLEN); // 5 for RV32, 6 for RV64

    // Adder and subtractor
    // ------------------------------
    logic [XLEN:0]       sub_wide;   // Extra top bit is the borrow
    logic [XLEN-1:0]     sub_result;
    logic                sign_diff;  // Operand signs disagree

    assign o_add_result = i_lhs + i_rhs;
    assign sub_wide     = {1'b0, i_lhs} - {1'b0, i_rhs};
    assign sub_result   = sub_wide[XLEN-1:0];

    // Comparator
    // ------------------------------
    // Signed result comes from the difference unless the signs differ,
    // in which case the negative operand is the smaller one
    assign sign_diff     = i_lhs[XLEN-1] ^ i_rhs[XLEN-1];
    assign o_eq          = (i_lhs == i_rhs);
    assign o_lt_unsigned = sub_wide[XLEN];                        // Borrow out
    assign o_lt_signed   = sign_diff ? i_lhs[XLEN-1] : sub_result[XLEN-1];

    // Shifter
    // ------------------------------
    logic [SHAMT_W-1:0]  shamt;
    logic [XLEN-1:0]     sll_result;
    logic [XLEN-1:0]     srl_result;
    logic [XLEN-1:0]     sra_result;

    assign shamt      = i_rhs[SHAMT_W-1:0];                   // Low bits only
    assign sll_result = i_lhs << shamt;
    assign srl_result = i_lhs >> shamt;
    assign sra_result = $unsigned($signed(i_lhs) >>> shamt);  // Sign fill

    // Result select
    // ------------------------------
    always_comb begin
        case (i_uop)
            exu_pkg::UOP_ADD:  o_result = o_add_result;
            exu_pkg::UOP_SUB:  o_result = sub_result;
            exu_pkg::UOP_XOR:  o_result = i_lhs ^ i_rhs;
            exu_pkg::UOP_OR:   o_result = i_lhs | i_rhs;
            exu_pkg::UOP_AND:  o_result = i_lhs & i_rhs;
            exu_pkg::UOP_SLL:  o_result = sll_result;
            exu_pkg::UOP_SRL:  o_result = srl_result;
            exu_pkg::UOP_SRA:  o_result = sra_result;
            exu_pkg::UOP_SLT:  o_result = {{(XLEN-1){1'b0}}, o_lt_signed};
            exu_pkg::UOP_SLTU: o_result = {{(XLEN-1){1'b0}}, o_lt_unsigned};
            default:           o_result = '0; // Not an ALU op
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/exu_pkg.sv
/*
 * Shared encodings for the execute stage: functional-unit select bits,
 * micro-op codes and instruction field types. Modules refer to these
 * by scoped names and never import the package.
 */
`default_nettype none

package exu_pkg;

    // Field types
    // ------------------------------
    typedef logic [3:0]  fu_t;       // One-hot functional unit select
    typedef logic [4:0]  uop_t;      // Micro-op code
    typedef logic [1:0]  size_t;     // Instruction size
    typedef logic [31:0] instr_t;    // Raw instruction word
    typedef logic [4:0]  reg_addr_t; // Register file address

    localparam int unsigned TRAP_CAUSE_W = 6; // Cause field in operand B

    // Functional unit bit positions
    // ------------------------------
    localparam int unsigned FU_ALU = 0; // Integer ALU
    localparam int unsigned FU_LSU = 1; // Load/store address path
    localparam int unsigned FU_CFU = 2; // Control flow
    localparam int unsigned FU_CSR = 3; // CSR access

    // ALU micro-ops
    // ------------------------------
    localparam uop_t UOP_ADD  = 5'b00001;
    localparam uop_t UOP_SUB  = 5'b00010;
    localparam uop_t UOP_XOR  = 5'b00011;
    localparam uop_t UOP_OR   = 5'b00100;
    localparam uop_t UOP_AND  = 5'b00101;
    localparam uop_t UOP_SLL  = 5'b00110;
    localparam uop_t UOP_SRL  = 5'b00111;
    localparam uop_t UOP_SRA  = 5'b01000;
    localparam uop_t UOP_SLT  = 5'b01001; // Signed compare
    localparam uop_t UOP_SLTU = 5'b01010; // Unsigned compare

    // Control flow micro-ops
    // ------------------------------
    // Conditional branches live in the 00xxx group, jumps in 10xxx
    localparam uop_t UOP_BEQ  = 5'b00001;
    localparam uop_t UOP_BNE  = 5'b00010;
    localparam uop_t UOP_BLT  = 5'b00011;
    localparam uop_t UOP_BGE  = 5'b00100;
    localparam uop_t UOP_BLTU = 5'b00101;
    localparam uop_t UOP_BGEU = 5'b00110;
    localparam uop_t UOP_JALI = 5'b10001; // Jump, target in operand C
    localparam uop_t UOP_JALR = 5'b10010; // Jump, target is A+B

    // Rewritten codes once a branch is resolved
    localparam uop_t UOP_TAKEN     = 5'b01001;
    localparam uop_t UOP_NOT_TAKEN = 5'b01010;

    // Load/store micro-op flags
    // ------------------------------
    // Low three bits carry the access width, which this stage ignores
    localparam int unsigned LSU_LOAD_BIT  = 3; // Set for loads
    localparam int unsigned LSU_STORE_BIT = 4; // Set for stores

endpackage

`default_nettype wire
